// File: design/axil_gpio_regs.sv
// AXI4-Lite register block for GPIO pads and the cipher
// Holds out/oe, key and data, and reads back result, status and pad inputs

module axil_gpio_regs import capture_pkg::*; (
  input  logic                 clk_main_i,
  input  logic                 rst_i,
  input  logic [AxilAddrW-1:0] s_axil_awaddr_i,
  input  logic                 s_axil_awvalid_i,
  output logic                 s_axil_awready_o,
  input  logic [AxilDataW-1:0] s_axil_wdata_i,
  input  logic [AxilStrbW-1:0] s_axil_wstrb_i,
  input  logic                 s_axil_wvalid_i,
  output logic                 s_axil_wready_o,
  output logic [1:0]           s_axil_bresp_o,
  output logic                 s_axil_bvalid_o,
  input  logic                 s_axil_bready_i,
  input  logic [AxilAddrW-1:0] s_axil_araddr_i,
  input  logic                 s_axil_arvalid_i,
  output logic                 s_axil_arready_o,
  output logic [AxilDataW-1:0] s_axil_rdata_o,
  output logic [1:0]           s_axil_rresp_o,
  output logic                 s_axil_rvalid_o,
  input  logic                 s_axil_rready_i,
  output pad_req_t             pad_req_o,
  output cipher_cmd_t          cipher_cmd_o,
  input  cipher_rsp_t          cipher_rsp_i,
  input  logic [NumPads-1:0]   pad_in_i
);

  logic                 wr_en, rd_en;
  logic                 bvalid_q, rvalid_q, start_q;
  logic [AxilDataW-1:0] wmask, rdata_q, rdata_d;
  logic [NumPads-1:0]   gpio_out_q, gpio_oe_q;
  logic [CipherW-1:0]   key_q, data_q;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Both channels in one cycle, held off while a response waits
  assign wr_en = s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_q;
  assign rd_en = s_axil_arvalid_i & ~rvalid_q;

  assign s_axil_awready_o = wr_en;
  assign s_axil_wready_o  = wr_en;
  assign s_axil_arready_o = rd_en;

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (s_axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Write decode
  //////////////////////////////

  // Expand byte strobes to a bit mask
  always_comb begin
    for (int b = 0; b < AxilStrbW; b++) begin
      wmask[b*8 +: 8] = {8{s_axil_wstrb_i[b]}};
    end
  end

  // GPIO state and the start pulse
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      start_q    <= 1'b0;
    end else begin
      start_q <= wr_en && (s_axil_awaddr_i == RegData);
      if (wr_en && (s_axil_awaddr_i == RegGpioOut)) begin
        gpio_out_q <= (gpio_out_q & ~wmask[NumPads-1:0])
                    | (s_axil_wdata_i[NumPads-1:0] & wmask[NumPads-1:0]);
      end
      if (wr_en && (s_axil_awaddr_i == RegGpioOe)) begin
        gpio_oe_q <= (gpio_oe_q & ~wmask[NumPads-1:0])
                   | (s_axil_wdata_i[NumPads-1:0] & wmask[NumPads-1:0]);
      end
    end
  end

  // Cipher operands
  always_ff @(posedge clk_main_i) begin
    if (wr_en && (s_axil_awaddr_i == RegKey)) begin
      key_q <= (key_q & ~wmask) | (s_axil_wdata_i & wmask);
    end
    if (wr_en && (s_axil_awaddr_i == RegData)) begin
      data_q <= (data_q & ~wmask) | (s_axil_wdata_i & wmask);
    end
  end

  //////////////////////////////
  // Readback
  //////////////////////////////

  always_comb begin
    unique case (s_axil_araddr_i)
      RegGpioOut: rdata_d = {{(AxilDataW-NumPads){1'b0}}, gpio_out_q};
      RegGpioOe:  rdata_d = {{(AxilDataW-NumPads){1'b0}}, gpio_oe_q};
      RegKey:     rdata_d = key_q;
      RegData:    rdata_d = data_q;
      RegResult:  rdata_d = cipher_rsp_i.result;
      RegStatus:  rdata_d = {{(AxilDataW-1){1'b0}}, cipher_rsp_i.busy};
      RegPadIn:   rdata_d = {{(AxilDataW-NumPads){1'b0}}, pad_in_i};
      default:    rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_main_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_bresp_o  = RespOkay;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rdata_o  = rdata_q;
  assign s_axil_rresp_o  = RespOkay;

  assign pad_req_o.out = gpio_out_q;
  assign pad_req_o.oe  = gpio_oe_q;

  assign cipher_cmd_o.start = start_q;
  assign cipher_cmd_o.key   = key_q;
  assign cipher_cmd_o.data  = data_q;

  // Write response must wait for the host
  bvalid_held_a: assert property (@(posedge clk_main_i) disable iff (rst_i)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

endmodule

// File: design/capture_io_top.sv
// Capture board I/O top level
// Register block, cipher, trigger gate and pad overlay

module capture_io_top import capture_pkg::*; (
  input  logic                 clk_main_i,
  input  logic                 rst_i,
  input  logic [AxilAddrW-1:0] s_axil_awaddr_i,
  input  logic                 s_axil_awvalid_i,
  output logic                 s_axil_awready_o,
  input  logic [AxilDataW-1:0] s_axil_wdata_i,
  input  logic [AxilStrbW-1:0] s_axil_wstrb_i,
  input  logic                 s_axil_wvalid_i,
  output logic                 s_axil_wready_o,
  output logic [1:0]           s_axil_bresp_o,
  output logic                 s_axil_bvalid_o,
  input  logic                 s_axil_bready_i,
  input  logic [AxilAddrW-1:0] s_axil_araddr_i,
  input  logic                 s_axil_arvalid_i,
  output logic                 s_axil_arready_o,
  output logic [AxilDataW-1:0] s_axil_rdata_o,
  output logic [1:0]           s_axil_rresp_o,
  output logic                 s_axil_rvalid_o,
  input  logic                 s_axil_rready_i,
  input  logic [NumPads-1:0]   pads_in_i,
  output logic [NumPads-1:0]   pads_out_o,
  output logic [NumPads-1:0]   pads_oe_o
);

  pad_req_t           regs_pad_req, gate_pad_req;
  cipher_cmd_t        cipher_cmd;
  cipher_rsp_t        cipher_rsp;
  logic [NumPads-1:0] pad_in_sync;

  axil_gpio_regs u_regs (
    .clk_main_i       (clk_main_i),
    .rst_i            (rst_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .pad_req_o        (regs_pad_req),
    .cipher_cmd_o     (cipher_cmd),
    .cipher_rsp_i     (cipher_rsp),
    .pad_in_i         (pad_in_sync)
  );

  cipher_round_unit u_cipher (
    .clk_main_i   (clk_main_i),
    .rst_i        (rst_i),
    .cipher_cmd_i (cipher_cmd),
    .cipher_rsp_o (cipher_rsp)
  );

  // Output pipeline, gate then overlay
  trigger_gate u_trigger_gate (
    .clk_main_i (clk_main_i),
    .rst_i      (rst_i),
    .pad_req_i  (regs_pad_req),
    .busy_i     (cipher_rsp.busy),
    .pad_req_o  (gate_pad_req)
  );

  pad_overlay_mux u_pad_overlay (
    .clk_main_i (clk_main_i),
    .rst_i      (rst_i),
    .pad_req_i  (gate_pad_req),
    .busy_i     (cipher_rsp.busy),
    .pads_in_i  (pads_in_i),
    .pads_out_o (pads_out_o),
    .pads_oe_o  (pads_oe_o),
    .pad_in_o   (pad_in_sync)
  );

endmodule

// File: design/capture_pkg.sv
// Capture board I/O subsystem shared definitions
// Pad map, register map, cipher constants and stage structs

package capture_pkg;

  //////////////////////////////
  // Pad map
  //////////////////////////////

  localparam int NumPads       = 20;
  // Scope trigger, gated by cipher activity
  localparam int PadIdxTrigger = 15;
  // Busy probe when the debug strap is set
  localparam int PadIdxProbe   = 14;
  localparam int PadIdxStrap   = 16;

  //////////////////////////////
  // Bus and register map
  //////////////////////////////

  localparam int AxilAddrW = 32;
  localparam int AxilDataW = 32;
  localparam int AxilStrbW = AxilDataW / 8;

  localparam logic [1:0] RespOkay = 2'b00;

  localparam logic [AxilAddrW-1:0] RegGpioOut = 32'h00;
  localparam logic [AxilAddrW-1:0] RegGpioOe  = 32'h04;
  localparam logic [AxilAddrW-1:0] RegKey     = 32'h08;
  // Write starts the cipher
  localparam logic [AxilAddrW-1:0] RegData    = 32'h0C;
  localparam logic [AxilAddrW-1:0] RegResult  = 32'h10;
  localparam logic [AxilAddrW-1:0] RegStatus  = 32'h14;
  localparam logic [AxilAddrW-1:0] RegPadIn   = 32'h18;

  //////////////////////////////
  // Cipher
  //////////////////////////////

  localparam int CipherW   = 32;
  localparam int NumRounds = 8;
  localparam int RotAmount = 5;

  //////////////////////////////
  // Stage structs
  //////////////////////////////

  typedef struct packed {
    logic [NumPads-1:0] out;
    logic [NumPads-1:0] oe;
  } pad_req_t;

  typedef struct packed {
    logic               start;
    logic [CipherW-1:0] key;
    logic [CipherW-1:0] data;
  } cipher_cmd_t;

  typedef struct packed {
    logic               busy;
    logic [CipherW-1:0] result;
  } cipher_rsp_t;

endpackage

// File: design/cipher_round_unit.sv
// Toy round cipher for side-channel capture
// Rotate-and-xor rounds, one per busy cycle

module cipher_round_unit import capture_pkg::*; (
  input  logic        clk_main_i,
  input  logic        rst_i,
  input  cipher_cmd_t cipher_cmd_i,
  output cipher_rsp_t cipher_rsp_o
);

  localparam int CntW = $clog2(NumRounds);

  logic               busy_q;
  logic [CntW-1:0]    round_q;
  logic [CipherW-1:0] state_q, key_q, result_q, state_next;

  function automatic logic [CipherW-1:0] rotl(input logic [CipherW-1:0] x);
    return (x << RotAmount) | (x >> (CipherW - RotAmount));
  endfunction

  assign state_next = rotl(state_q) ^ key_q;

  // Control
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      round_q <= '0;
    end else if (!busy_q) begin
      // start while busy is dropped
      if (cipher_cmd_i.start) begin
        busy_q  <= 1'b1;
        round_q <= '0;
      end
    end else begin
      round_q <= round_q + 1'b1;
      if (round_q == CntW'(NumRounds - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Datapath
  always_ff @(posedge clk_main_i) begin
    if (!busy_q && cipher_cmd_i.start) begin
      state_q <= cipher_cmd_i.data;
      key_q   <= cipher_cmd_i.key;
    end else if (busy_q) begin
      state_q <= state_next;
      if (round_q == CntW'(NumRounds - 1)) begin
        result_q <= state_next;
      end
    end
  end

  assign cipher_rsp_o.busy   = busy_q;
  assign cipher_rsp_o.result = result_q;

  // Busy window is exactly the round count
  busy_len_a: assert property (@(posedge clk_main_i) disable iff (rst_i)
    $rose(busy_q) |-> ##NumRounds !busy_q);

endmodule

// File: design/pad_overlay_mux.sv
// Pad overlay stage and input synchronizer
// Strap selects a busy probe on the probe pad

module pad_overlay_mux import capture_pkg::*; (
  input  logic               clk_main_i,
  input  logic               rst_i,
  input  pad_req_t           pad_req_i,
  input  logic               busy_i,
  input  logic [NumPads-1:0] pads_in_i,
  output logic [NumPads-1:0] pads_out_o,
  output logic [NumPads-1:0] pads_oe_o,
  output logic [NumPads-1:0] pad_in_o
);

  logic [NumPads-1:0] sync_q1, sync_q2;
  logic               strap_q, strap_done_q;
  logic               busy_d_q;
  pad_req_t           pads_d, pads_q;

  //////////////////////////////
  // Input synchronizer
  //////////////////////////////

  always_ff @(posedge clk_main_i) begin
    sync_q1 <= pads_in_i;
    sync_q2 <= sync_q1;
  end

  assign pad_in_o = sync_q2;

  //////////////////////////////
  // Strap sampling
  //////////////////////////////

  // One shot, first cycle out of reset
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      strap_q      <= 1'b0;
      strap_done_q <= 1'b0;
    end else if (!strap_done_q) begin
      strap_q      <= sync_q2[PadIdxStrap];
      strap_done_q <= 1'b1;
    end
  end

  //////////////////////////////
  // Overlay and output flops
  //////////////////////////////

  // Extra delay lines the probe up with the gated trigger
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      busy_d_q <= 1'b0;
    end else begin
      busy_d_q <= busy_i;
    end
  end

  always_comb begin
    pads_d = pad_req_i;
    if (strap_q) begin
      pads_d.out[PadIdxProbe] = busy_d_q;
      pads_d.oe[PadIdxProbe]  = 1'b1;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      pads_q <= '0;
    end else begin
      pads_q <= pads_d;
    end
  end

  assign pads_out_o = pads_q.out;
  assign pads_oe_o  = pads_q.oe;

  // Strap is frozen once sampled
  strap_stable_a: assert property (@(posedge clk_main_i) disable iff (rst_i)
    strap_done_q |=> $stable(strap_q));

endmodule

// File: design/trigger_gate.sv
// Capture trigger gate
// Trigger pad only toggles while the cipher runs

module trigger_gate import capture_pkg::*; (
  input  logic     clk_main_i,
  input  logic     rst_i,
  input  pad_req_t pad_req_i,
  input  logic     busy_i,
  output pad_req_t pad_req_o
);

  pad_req_t req_gated;
  pad_req_t req_q;

  // Narrow the software trigger to the busy window
  always_comb begin
    req_gated = pad_req_i;
    req_gated.out[PadIdxTrigger] = pad_req_i.out[PadIdxTrigger] & busy_i;
  end

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      req_q <= '0;
    end else begin
      req_q <= req_gated;
    end
  end

  assign pad_req_o = req_q;

endmodule

// File: project.f
design/capture_pkg.sv
design/axil_gpio_regs.sv
design/cipher_round_unit.sv
design/trigger_gate.sv
design/pad_overlay_mux.sv
design/capture_io_top.sv
tb/tb_capture_io_top.sv

// File: tb/tb_capture_io_top.sv
// Testbench for the capture board I/O top level
// Table-driven AXI4-Lite traffic with GPIO, pad input, cipher, trigger and strap checks

module tb_capture_io_top import capture_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          WatchCycles   = 14;
  localparam int          CyclesPerTest = 50;
  localparam logic [31:0] LfsrSeed      = 32'h1812161e;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LfsrTaps      = 32'h80200003;

  typedef enum int {OpReset, OpWrOut, OpRd, OpPadIn, OpCipher, OpWatch} op_e;

  typedef struct {
    string       name;
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } test_t;

  logic                 clk_main_i;
  logic                 rst_i;
  logic [AxilAddrW-1:0] s_axil_awaddr_i;
  logic                 s_axil_awvalid_i;
  logic                 s_axil_awready_o;
  logic [AxilDataW-1:0] s_axil_wdata_i;
  logic [AxilStrbW-1:0] s_axil_wstrb_i;
  logic                 s_axil_wvalid_i;
  logic                 s_axil_wready_o;
  logic [1:0]           s_axil_bresp_o;
  logic                 s_axil_bvalid_o;
  logic                 s_axil_bready_i;
  logic [AxilAddrW-1:0] s_axil_araddr_i;
  logic                 s_axil_arvalid_i;
  logic                 s_axil_arready_o;
  logic [AxilDataW-1:0] s_axil_rdata_o;
  logic [1:0]           s_axil_rresp_o;
  logic                 s_axil_rvalid_o;
  logic                 s_axil_rready_i;
  logic [NumPads-1:0]   pads_in_i;
  logic [NumPads-1:0]   pads_out_o;
  logic [NumPads-1:0]   pads_oe_o;

  test_t       tests[$];
  logic [31:0] lfsr_q;
  int          cycle_count;
  int          timeout_limit;

  capture_io_top uut (
    .clk_main_i       (clk_main_i),
    .rst_i            (rst_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .pads_in_i        (pads_in_i),
    .pads_out_o       (pads_out_o),
    .pads_oe_o        (pads_oe_o)
  );

  initial begin
    clk_main_i = 1'b0;
    forever #5 clk_main_i = ~clk_main_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compare_values(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
    if (exp !== act) begin
      abort_run($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w      = {lfsr_q[0], w[31:1]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Rotate left by RotAmount then xor key, NumRounds times
  function automatic logic [31:0] cipher_model(input logic [31:0] key, input logic [31:0] data);
    logic [31:0] s;
    s = data;
    for (int r = 0; r < NumRounds; r++) begin
      s = {s[31-RotAmount:0], s[31:32-RotAmount]} ^ key;
    end
    return s;
  endfunction

  task automatic add_test(input string name, input op_e op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
    test_t t;
    t.name = name;
    t.op   = op;
    t.addr = addr;
    t.data = data;
    t.exp  = exp;
    tests.push_back(t);
  endtask

  //////////////////////////////
  // Bus and reset drivers
  //////////////////////////////

  // Holds bready low for the cycle after acceptance, returns 1 ns after the next edge
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    logic ready;
    s_axil_awaddr_i  = addr;
    s_axil_wdata_i   = data;
    s_axil_wstrb_i   = '1;
    s_axil_awvalid_i = 1'b1;
    s_axil_wvalid_i  = 1'b1;
    do begin
      @(negedge clk_main_i);
      ready = s_axil_awready_o;
      if (ready) begin
        compare_values("axil_wready", 1, s_axil_wready_o);
      end
      @(posedge clk_main_i);
      #1;
    end while (!ready);
    s_axil_awvalid_i = 1'b0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_bready_i  = 1'b0;
    compare_values("axil_bvalid", 1, s_axil_bvalid_o);
    compare_values("axil_bresp", RespOkay, s_axil_bresp_o);
    @(posedge clk_main_i);
    #1;
    compare_values("axil_bvalid_held", 1, s_axil_bvalid_o);
    s_axil_bready_i = 1'b1;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    logic ready;
    s_axil_araddr_i  = addr;
    s_axil_arvalid_i = 1'b1;
    do begin
      @(negedge clk_main_i);
      ready = s_axil_arready_o;
      @(posedge clk_main_i);
      #1;
    end while (!ready);
    s_axil_arvalid_i = 1'b0;
    compare_values("axil_rvalid", 1, s_axil_rvalid_o);
    compare_values("axil_rresp", RespOkay, s_axil_rresp_o);
    data = s_axil_rdata_o;
  endtask

  task automatic apply_reset(input string name, input logic [31:0] pad_level);
    rst_i     = 1'b1;
    pads_in_i = pad_level[NumPads-1:0];
    repeat (5) @(posedge clk_main_i);
    #1;
    rst_i = 1'b0;
    compare_values($sformatf("%s_pads_out", name), '0, pads_out_o);
    compare_values($sformatf("%s_pads_oe", name), '0, pads_oe_o);
    compare_values($sformatf("%s_resp", name), '0, {s_axil_bvalid_o, s_axil_rvalid_o});
    compare_values($sformatf("%s_ready", name), '0,
                   {s_axil_awready_o, s_axil_wready_o, s_axil_arready_o});
  endtask

  //////////////////////////////
  // Test operations
  //////////////////////////////

  task automatic run_cipher(input test_t t);
    logic [31:0] key, first, second, rd;
    for (int r = 0; r < t.data; r++) begin
      rand_word(key);
      rand_word(first);
      rand_word(second);
      axil_write(RegKey, key);
      axil_write(RegData, first);
      // Lands while busy, must be dropped
      axil_write(RegData, second);
      axil_read(RegStatus, rd);
      compare_values($sformatf("%s_busy", t.name), 1, rd);
      while (rd[0]) begin
        axil_read(RegStatus, rd);
      end
      axil_read(RegResult, rd);
      compare_values($sformatf("%s_result", t.name), cipher_model(key, first), rd);
    end
  endtask

  // Counts high cycles on one pad across a cipher run
  task automatic watch_pin(input test_t t);
    int          high_count;
    logic        idle;
    logic [31:0] d;
    idle = (t.exp == WatchCycles);
    compare_values($sformatf("%s_idle_before", t.name), idle, pads_out_o[t.addr]);
    compare_values($sformatf("%s_oe", t.name), 1, pads_oe_o[t.addr]);
    rand_word(d);
    axil_write(RegData, d);
    high_count = 0;
    repeat (WatchCycles) begin
      @(posedge clk_main_i);
      #1;
      if (pads_out_o[t.addr]) begin
        high_count++;
      end
    end
    compare_values($sformatf("%s_high_cycles", t.name), t.exp, high_count);
    compare_values($sformatf("%s_idle_after", t.name), idle, pads_out_o[t.addr]);
  endtask

  task automatic run_test(input test_t t);
    logic [31:0] rd;
    case (t.op)
      OpReset: apply_reset(t.name, t.data);
      OpWrOut: begin
        axil_write(t.addr, t.data);
        // Pads follow 2 cycles after acceptance, one after the write returns
        @(posedge clk_main_i);
        #1;
        if (t.addr == RegGpioOe) begin
          compare_values(t.name, t.exp, pads_oe_o);
        end else begin
          compare_values(t.name, t.exp, pads_out_o);
        end
      end
      OpRd: begin
        axil_read(t.addr, rd);
        compare_values(t.name, t.exp, rd);
      end
      OpPadIn: begin
        pads_in_i = t.data[NumPads-1:0];
        repeat (3) @(posedge clk_main_i);
        #1;
        axil_read(RegPadIn, rd);
        compare_values(t.name, t.exp, rd);
      end
      OpCipher: run_cipher(t);
      OpWatch:  watch_pin(t);
      default:  abort_run($sformatf("Test %s has an unknown operation", t.name));
    endcase
  endtask

  //////////////////////////////
  // Test table and main flow
  //////////////////////////////

  initial begin
    rst_i            = 1'b1;
    s_axil_awaddr_i  = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i   = '0;
    s_axil_wstrb_i   = '0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_bready_i  = 1'b1;
    s_axil_araddr_i  = '0;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i  = 1'b1;
    pads_in_i        = '0;
    lfsr_q           = LfsrSeed;

    add_test("reset_strap_low", OpReset,  0,          32'h00000,    0);
    add_test("gpio_out",        OpWrOut,  RegGpioOut, 32'h34A5C,    32'h34A5C);
    add_test("gpio_oe",         OpWrOut,  RegGpioOe,  32'hC3F0F,    32'hC3F0F);
    add_test("gpio_out_rb",     OpRd,     RegGpioOut, 0,            32'h34A5C);
    add_test("gpio_oe_rb",      OpRd,     RegGpioOe,  0,            32'hC3F0F);
    add_test("gpio_out_upper",  OpWrOut,  RegGpioOut, 32'hFFF43210, 32'h43210);
    add_test("gpio_out_rb2",    OpRd,     RegGpioOut, 0,            32'h43210);
    add_test("pad_in_a",        OpPadIn,  0,          32'h5A5A5,    32'h5A5A5);
    add_test("pad_in_b",        OpPadIn,  0,          32'hFFFFFFFF, 32'hFFFFF);
    add_test("unmapped_read",   OpRd,     32'h1C,     0,            0);
    add_test("cipher",          OpCipher, 0,          3,            0);
    // Trigger bit set while idle stays low on the pad
    add_test("trig_oe",         OpWrOut,  RegGpioOe,  32'hFFFFF,    32'hFFFFF);
    add_test("trig_out_idle",   OpWrOut,  RegGpioOut, 32'h0C000,    32'h04000);
    add_test("trig_watch",      OpWatch,  15,         0,            NumRounds);
    add_test("gpio14_watch",    OpWatch,  14,         0,            WatchCycles);
    add_test("reset_strap_set", OpReset,  0,          32'h10000,    0);
    add_test("probe_oe",        OpWrOut,  RegGpioOe,  32'h00001,    32'h04001);
    add_test("probe_out",       OpWrOut,  RegGpioOut, 32'h04001,    32'h00001);
    add_test("probe_watch",     OpWatch,  14,         0,            NumRounds);
    add_test("cipher_strap",    OpCipher, 0,          1,            0);
    timeout_limit = CyclesPerTest * tests.size();

    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk_main_i);
      cycle_count++;
      if (cycle_count > timeout_limit) begin
        abort_run($sformatf("Run did not finish within %0d cycles", timeout_limit));
      end
    end
  end

endmodule
